//--- build.f
udp_pkg.sv
ip_hdr_checksum.sv
udp_rx_parser.sv
udp_tx_builder.sv
udp_endpoint.sv
tb_udp_endpoint.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_udp_endpoint
FILELIST  := build.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))
LOG       := sim.log

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "All tests passed" $(LOG) || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_udp_endpoint.sv
`timescale 1ns/1ps
`default_nettype none

module tb_udp_endpoint import udp_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int TX_REQUESTS    = 20;
    localparam int RX_FRAMES      = 60;
    localparam int MIN_FRAME      = 60;

    logic        clk;
    logic        arst_n;
    logic [47:0] local_mac;
    logic [31:0] local_ip;
    byte_beat_t  rx_frame;
    logic        rx_frame_valid;
    logic        rx_frame_ready;
    udp_rx_hdr_t rx_hdr;
    logic        rx_hdr_valid;
    logic        rx_hdr_ready;
    byte_beat_t  rx_payload;
    logic        rx_payload_valid;
    logic        rx_payload_ready;
    udp_tx_hdr_t tx_hdr;
    logic        tx_hdr_valid;
    logic        tx_hdr_ready;
    byte_beat_t  tx_payload;
    logic        tx_payload_valid;
    logic        tx_payload_ready;
    byte_beat_t  tx_frame;
    logic        tx_frame_valid;
    logic        tx_frame_ready;

    // Expected results that the model fills before the stimulus goes out
    byte_beat_t  exp_tx[$];
    udp_rx_hdr_t exp_hdr[$];
    byte_beat_t  exp_pay[$];
    int          good_frames = 0;
    int          bad_frames = 0;

    logic [31:0] lfsr = 32'hce7b527f;

    udp_endpoint dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic tick_with_timeout(inout int n, input string what);
        @(posedge clk);
        n++;
        if (n > TIMEOUT_CYCLES) begin
            abort_run({"Timeout while waiting for ", what});
        end
    endtask

    task automatic random_gap();
        int g;
        g = 0;
        while (g < 3 && rand_bits(2) == 32'd0) begin
            @(negedge clk);
            g++;
        end
    endtask

    task automatic check_frame_byte(input byte_beat_t got, input byte_beat_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR tx_frame: got data %h last %h, expected data %h last %h",
                                got.data, got.last, exp.data, exp.last));
        end
    endtask

    task automatic check_rx_hdr(input udp_rx_hdr_t got, input udp_rx_hdr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR rx_hdr: got %h, expected %h", got, exp));
        end
    endtask

    task automatic check_payload_byte(input byte_beat_t got, input byte_beat_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR rx_payload: got data %h last %h, expected data %h last %h",
                                got.data, got.last, exp.data, exp.last));
        end
    endtask

    // Reference frame header with byte 0 in the top bits
    function automatic logic [FRAME_HDR_BYTES*8-1:0] make_header(
        input logic [47:0] dst_mac,
        input logic [47:0] src_mac,
        input logic [15:0] ethertype,
        input logic [7:0]  ver_ihl,
        input logic [7:0]  proto,
        input logic [31:0] src_ip,
        input logic [31:0] dst_ip,
        input logic [15:0] src_port,
        input logic [15:0] dst_port,
        input logic [15:0] len
    );
        logic [159:0] ip;
        logic [31:0]  sum;
        ip  = {ver_ihl, 8'h00, 16'd28 + len, 32'h0, 8'd64, proto, 16'h0, src_ip, dst_ip};
        sum = '0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + 32'(ip[159 - 16*i -: 16]);
        end
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        ip[79:64] = ~sum[15:0];
        return {dst_mac, src_mac, ethertype, ip, src_port, dst_port, len + 16'd8, 16'h0};
    endfunction

    function automatic logic [7:0] hdr_byte(input logic [FRAME_HDR_BYTES*8-1:0] hdr, input int i);
        return hdr[FRAME_HDR_BYTES*8 - 1 - 8*i -: 8];
    endfunction

    task automatic send_rx_byte(input logic [7:0] data, input logic last);
        int n;
        random_gap();
        rx_frame.data  = data;
        rx_frame.last  = last;
        rx_frame_valid = 1'b1;
        n = 0;
        do tick_with_timeout(n, "rx_frame_ready"); while (!rx_frame_ready);
        @(negedge clk);
        rx_frame_valid = 1'b0;
    endtask

    task automatic send_tx_payload(input logic [7:0] data, input logic last);
        int n;
        random_gap();
        tx_payload.data  = data;
        tx_payload.last  = last;
        tx_payload_valid = 1'b1;
        n = 0;
        do tick_with_timeout(n, "tx_payload_ready"); while (!tx_payload_ready);
        @(negedge clk);
        tx_payload_valid = 1'b0;
    endtask

    task automatic run_tx_requests();
        logic [FRAME_HDR_BYTES*8-1:0] hdr;
        logic [31:0] dst_ip;
        logic [15:0] dst_port;
        logic [15:0] len;
        logic [7:0]  pay[$];
        byte_beat_t  beat;
        int          n;
        for (int r = 0; r < TX_REQUESTS; r++) begin
            dst_ip   = rand_bits(32);
            dst_port = 16'(rand_bits(16));
            len      = 16'(rand_bits(6) % 32'd33);
            pay.delete();
            for (int i = 0; i < int'(len); i++) begin
                pay.push_back(8'(rand_bits(8)));
            end
            hdr = make_header(48'hffff_ffff_ffff, local_mac, 16'h0800, 8'h45, 8'd17,
                              local_ip, dst_ip, 16'd1234, dst_port, len);
            for (int i = 0; i < FRAME_HDR_BYTES; i++) begin
                beat.data = hdr_byte(hdr, i);
                beat.last = (i == FRAME_HDR_BYTES - 1) && (len == 16'd0);
                exp_tx.push_back(beat);
            end
            for (int i = 0; i < int'(len); i++) begin
                beat.data = pay[i];
                beat.last = (i == int'(len) - 1);
                exp_tx.push_back(beat);
            end
            random_gap();
            tx_hdr       = {dst_ip, dst_port, len};
            tx_hdr_valid = 1'b1;
            n = 0;
            do tick_with_timeout(n, "tx_hdr_ready"); while (!tx_hdr_ready);
            @(negedge clk);
            tx_hdr_valid = 1'b0;
            for (int i = 0; i < int'(len); i++) begin
                send_tx_payload(pay[i], i == int'(len) - 1);
            end
        end
    endtask

    task automatic run_rx_frames();
        logic [FRAME_HDR_BYTES*8-1:0] hdr;
        logic [47:0] dst_mac;
        logic [15:0] ethertype;
        logic [7:0]  ver_ihl;
        logic [7:0]  proto;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] len;
        logic        good;
        logic [7:0]  pay[$];
        logic [7:0]  frm[$];
        byte_beat_t  beat;
        for (int f = 0; f < RX_FRAMES; f++) begin
            dst_mac   = (rand_bits(1) == 32'd1) ? 48'hffff_ffff_ffff : local_mac;
            ethertype = 16'h0800;
            ver_ihl   = 8'h45;
            proto     = 8'd17;
            dst_ip    = local_ip;
            src_ip    = rand_bits(32);
            src_port  = 16'(rand_bits(16));
            dst_port  = 16'(rand_bits(16));
            len       = 16'(rand_bits(6) % 32'd33);
            good      = (rand_bits(2) != 32'd0);
            // One field spoiled per bad frame
            if (!good) begin
                case (rand_bits(3) % 32'd5)
                    32'd0:   dst_mac = local_mac ^ 48'h1;
                    32'd1:   dst_ip = local_ip ^ 32'h100;
                    32'd2:   ethertype = 16'h86dd;
                    32'd3:   proto = 8'd6;
                    default: ver_ihl = 8'h46;
                endcase
            end
            hdr = make_header(dst_mac, 48'h0a00_0000_0001, ethertype, ver_ihl, proto,
                              src_ip, dst_ip, src_port, dst_port, len);
            pay.delete();
            frm.delete();
            for (int i = 0; i < int'(len); i++) begin
                pay.push_back(8'(rand_bits(8)));
            end
            for (int i = 0; i < FRAME_HDR_BYTES; i++) begin
                frm.push_back(hdr_byte(hdr, i));
            end
            foreach (pay[i]) begin
                frm.push_back(pay[i]);
            end
            // Ethernet padding up to the minimum frame
            while (frm.size() < MIN_FRAME) begin
                frm.push_back(8'(rand_bits(8)));
            end
            if (good) begin
                good_frames++;
                exp_hdr.push_back({src_ip, src_port, dst_port, len});
                for (int i = 0; i < int'(len); i++) begin
                    beat.data = pay[i];
                    beat.last = (i == int'(len) - 1);
                    exp_pay.push_back(beat);
                end
            end else begin
                bad_frames++;
            end
            for (int i = 0; i < frm.size(); i++) begin
                send_rx_byte(frm[i], i == frm.size() - 1);
            end
        end
    endtask

    // Output back-pressure
    initial begin
        rx_hdr_ready     = 1'b0;
        rx_payload_ready = 1'b0;
        tx_frame_ready   = 1'b0;
        forever begin
            @(negedge clk);
            rx_hdr_ready     = (rand_bits(2) != 32'd0);
            rx_payload_ready = (rand_bits(2) != 32'd0);
            tx_frame_ready   = (rand_bits(2) != 32'd0);
        end
    end

    always @(posedge clk) begin
        if (arst_n && tx_frame_valid && tx_frame_ready) begin
            if (exp_tx.size() == 0) begin
                abort_run("The DUT sent a tx_frame byte that no request asked for");
            end else begin
                check_frame_byte(tx_frame, exp_tx.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (arst_n && rx_hdr_valid && rx_hdr_ready) begin
            if (exp_hdr.size() == 0) begin
                abort_run("The DUT delivered an rx_hdr for a frame that should be dropped");
            end else begin
                check_rx_hdr(rx_hdr, exp_hdr.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (arst_n && rx_payload_valid && rx_payload_ready) begin
            if (exp_pay.size() == 0) begin
                abort_run("The DUT delivered an rx_payload byte that was not expected");
            end else begin
                check_payload_byte(rx_payload, exp_pay.pop_front());
            end
        end
    end

    initial begin
        int n;
        arst_n           = 1'b0;
        rx_frame         = '0;
        rx_frame_valid   = 1'b0;
        tx_hdr           = '0;
        tx_hdr_valid     = 1'b0;
        tx_payload       = '0;
        tx_payload_valid = 1'b0;
        // Unicast local MAC, so flipping bit 0 never gives broadcast
        local_mac = {8'h02, 8'(rand_bits(8)), rand_bits(32)};
        local_ip  = rand_bits(32);
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        fork
            run_tx_requests();
            run_rx_frames();
        join

        n = 0;
        while ((exp_tx.size() + exp_hdr.size() + exp_pay.size()) != 0 && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        $display("Frames received: %0d good, %0d dropped; requests sent: %0d",
                 good_frames, bad_frames, TX_REQUESTS);
        if ((exp_tx.size() + exp_hdr.size() + exp_pay.size()) == 0 && good_frames > 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            abort_run("The DUT did not deliver all expected frames and records in time");
        end
    end

endmodule

`default_nettype wire

//--- udp_endpoint.sv
`timescale 1ns/1ps
`default_nettype none

module udp_endpoint import udp_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [47:0] local_mac,
    input  logic [31:0] local_ip,
    // From the MAC
    input  byte_beat_t  rx_frame,
    input  logic        rx_frame_valid,
    output logic        rx_frame_ready,
    // To the application
    output udp_rx_hdr_t rx_hdr,
    output logic        rx_hdr_valid,
    input  logic        rx_hdr_ready,
    output byte_beat_t  rx_payload,
    output logic        rx_payload_valid,
    input  logic        rx_payload_ready,
    // From the application
    input  udp_tx_hdr_t tx_hdr,
    input  logic        tx_hdr_valid,
    output logic        tx_hdr_ready,
    input  byte_beat_t  tx_payload,
    input  logic        tx_payload_valid,
    output logic        tx_payload_ready,
    // To the MAC
    output byte_beat_t  tx_frame,
    output logic        tx_frame_valid,
    input  logic        tx_frame_ready
);

    udp_rx_parser u_rx_parser (
        .clk              (clk),
        .arst_n           (arst_n),
        .local_mac        (local_mac),
        .local_ip         (local_ip),
        .rx_frame         (rx_frame),
        .rx_frame_valid   (rx_frame_valid),
        .rx_frame_ready   (rx_frame_ready),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_payload       (rx_payload),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready)
    );

    udp_tx_builder u_tx_builder (
        .clk              (clk),
        .arst_n           (arst_n),
        .local_mac        (local_mac),
        .local_ip         (local_ip),
        .tx_hdr           (tx_hdr),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_payload       (tx_payload),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .tx_frame         (tx_frame),
        .tx_frame_valid   (tx_frame_valid),
        .tx_frame_ready   (tx_frame_ready)
    );

endmodule

`default_nettype wire

//--- udp_tx_builder.sv
`timescale 1ns/1ps
`default_nettype none

module udp_tx_builder import udp_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [47:0] local_mac,
    input  logic [31:0] local_ip,
    input  udp_tx_hdr_t tx_hdr,
    input  logic        tx_hdr_valid,
    output logic        tx_hdr_ready,
    input  byte_beat_t  tx_payload,
    input  logic        tx_payload_valid,
    output logic        tx_payload_ready,
    output byte_beat_t  tx_frame,
    output logic        tx_frame_valid,
    input  logic        tx_frame_ready
);

    tx_state_e   state;
    logic [15:0] cnt;
    udp_tx_hdr_t req_q;
    logic [15:0] ip_total_len;
    logic [15:0] udp_len;
    logic [15:0] ip_csum;
    logic [5:0]  hdr_idx;
    logic        hdr_last;
    logic        pay_last;
    logic        frame_xfer;

    // Byte 41 is the first on the wire
    logic [FRAME_HDR_BYTES-1:0][7:0] hdr_bytes;

    assign ip_total_len = 16'(IP_HDR_BYTES + UDP_HDR_BYTES) + req_q.payload_len;
    assign udp_len      = 16'(UDP_HDR_BYTES) + req_q.payload_len;

    ip_hdr_checksum u_ip_hdr_checksum (
        .total_length (ip_total_len),
        .source_ip    (local_ip),
        .dest_ip      (req_q.dst_ip),
        .checksum     (ip_csum)
    );

    assign hdr_bytes = {
        MAC_BROADCAST,
        local_mac,
        ETHERTYPE_IPV4,
        IP_VER_IHL,
        8'h00,
        ip_total_len,
        16'h0000,
        16'h0000,
        IP_TTL,
        IP_PROTO_UDP,
        ip_csum,
        local_ip,
        req_q.dst_ip,
        UDP_SRC_PORT,
        req_q.dst_port,
        udp_len,
        16'h0000
    };

    assign hdr_idx    = 6'(FRAME_HDR_BYTES - 1) - cnt[5:0];
    // An empty datagram ends on the UDP checksum
    assign hdr_last   = (cnt == 16'(FRAME_HDR_BYTES - 1)) && (req_q.payload_len == 16'd0);
    assign pay_last   = (cnt == req_q.payload_len - 16'd1);
    assign frame_xfer = tx_frame_valid && tx_frame_ready;

    assign tx_hdr_ready = (state == TX_IDLE);

    always_comb begin
        tx_frame_valid   = 1'b0;
        tx_frame.data    = hdr_bytes[hdr_idx];
        tx_frame.last    = hdr_last;
        tx_payload_ready = 1'b0;
        case (state)
            TX_HDR: tx_frame_valid = 1'b1;
            TX_PAYLOAD: begin
                tx_frame_valid   = tx_payload_valid;
                tx_frame.data    = tx_payload.data;
                tx_frame.last    = pay_last;
                tx_payload_ready = tx_frame_ready;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= TX_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (tx_hdr_valid) begin
                        state <= TX_HDR;
                        cnt   <= '0;
                    end
                end
                TX_HDR: begin
                    if (frame_xfer) begin
                        cnt <= cnt + 16'd1;
                        if (cnt == 16'(FRAME_HDR_BYTES - 1)) begin
                            cnt   <= '0;
                            state <= (req_q.payload_len == 16'd0) ? TX_IDLE : TX_PAYLOAD;
                        end
                    end
                end
                TX_PAYLOAD: begin
                    if (frame_xfer) begin
                        cnt <= cnt + 16'd1;
                        if (pay_last) begin
                            cnt   <= '0;
                            state <= TX_IDLE;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Request is held for the whole frame
    always_ff @(posedge clk) begin
        if (tx_hdr_valid && tx_hdr_ready) begin
            req_q <= tx_hdr;
        end
    end

    a_payload_len: assert property (@(posedge clk) disable iff (!arst_n)
        state == TX_PAYLOAD && tx_payload_valid && tx_payload_ready
        |-> tx_payload.last == pay_last);

endmodule

`default_nettype wire

//--- udp_rx_parser.sv
`timescale 1ns/1ps
`default_nettype none

module udp_rx_parser import udp_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [47:0] local_mac,
    input  logic [31:0] local_ip,
    input  byte_beat_t  rx_frame,
    input  logic        rx_frame_valid,
    output logic        rx_frame_ready,
    output udp_rx_hdr_t rx_hdr,
    output logic        rx_hdr_valid,
    input  logic        rx_hdr_ready,
    output byte_beat_t  rx_payload,
    output logic        rx_payload_valid,
    input  logic        rx_payload_ready
);

    rx_state_e   state;
    logic [15:0] cnt;
    logic        frame_done;
    logic [39:0] hdr_sr;
    udp_rx_hdr_t hdr_q;
    logic [47:0] cur;
    logic        byte_ok;
    logic        frame_xfer;
    logic        pay_last;

    // Last six header bytes including the one on the bus
    assign cur        = {hdr_sr, rx_frame.data};
    assign frame_xfer = rx_frame_valid && rx_frame_ready;
    assign pay_last   = (cnt == hdr_q.payload_len - 16'd1);

    // Filter checks at the final byte of each field
    always_comb begin
        case (cnt)
            16'd5:   byte_ok = (cur == local_mac) || (cur == MAC_BROADCAST);
            16'd13:  byte_ok = (cur[15:0] == ETHERTYPE_IPV4);
            16'd14:  byte_ok = (rx_frame.data == IP_VER_IHL);
            16'd23:  byte_ok = (rx_frame.data == IP_PROTO_UDP);
            16'd33:  byte_ok = (cur[31:0] == local_ip);
            16'd39:  byte_ok = (cur[15:0] >= 16'(UDP_HDR_BYTES));
            default: byte_ok = 1'b1;
        endcase
    end

    always_comb begin
        case (state)
            RX_HDR_OUT: rx_frame_ready = 1'b0;
            RX_PAYLOAD: rx_frame_ready = rx_payload_ready;
            default:    rx_frame_ready = 1'b1;
        endcase
    end

    assign rx_hdr       = hdr_q;
    assign rx_hdr_valid = (state == RX_HDR_OUT);

    // Payload passes straight through and a short frame ends early
    assign rx_payload.data  = rx_frame.data;
    assign rx_payload.last  = pay_last || rx_frame.last;
    assign rx_payload_valid = (state == RX_PAYLOAD) && rx_frame_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= RX_HDR;
            cnt        <= '0;
            frame_done <= 1'b0;
        end else begin
            case (state)
                RX_HDR: begin
                    if (frame_xfer) begin
                        cnt <= cnt + 16'd1;
                        if (!byte_ok) begin
                            cnt   <= '0;
                            state <= rx_frame.last ? RX_HDR : RX_DRAIN;
                        end else if (cnt == 16'(FRAME_HDR_BYTES - 1)) begin
                            cnt        <= '0;
                            frame_done <= rx_frame.last;
                            // A frame cut at the header is only kept when it has no payload
                            if (!rx_frame.last || hdr_q.payload_len == 16'd0) begin
                                state <= RX_HDR_OUT;
                            end
                        end else if (rx_frame.last) begin
                            cnt <= '0;
                        end
                    end
                end
                RX_HDR_OUT: begin
                    if (rx_hdr_ready) begin
                        if (hdr_q.payload_len == 16'd0) begin
                            state <= frame_done ? RX_HDR : RX_DRAIN;
                        end else begin
                            state <= RX_PAYLOAD;
                        end
                    end
                end
                RX_PAYLOAD: begin
                    if (frame_xfer) begin
                        cnt <= cnt + 16'd1;
                        if (pay_last || rx_frame.last) begin
                            cnt   <= '0;
                            // Anything after the datagram is Ethernet padding
                            state <= rx_frame.last ? RX_HDR : RX_DRAIN;
                        end
                    end
                end
                RX_DRAIN: begin
                    if (frame_xfer && rx_frame.last) begin
                        state <= RX_HDR;
                    end
                end
                default: state <= RX_HDR;
            endcase
        end
    end

    // Header field capture
    always_ff @(posedge clk) begin
        if (state == RX_HDR && frame_xfer) begin
            hdr_sr <= cur[39:0];
            case (cnt)
                16'd29: hdr_q.src_ip      <= cur[31:0];
                16'd35: hdr_q.src_port    <= cur[15:0];
                16'd37: hdr_q.dst_port    <= cur[15:0];
                16'd39: hdr_q.payload_len <= cur[15:0] - 16'(UDP_HDR_BYTES);
                default: ;
            endcase
        end
    end

    a_hdr_stable: assert property (@(posedge clk) disable iff (!arst_n)
        rx_hdr_valid && !rx_hdr_ready |=> rx_hdr_valid && $stable(rx_hdr));

    // Payload count never passes the datagram length
    a_payload_count: assert property (@(posedge clk) disable iff (!arst_n)
        state == RX_PAYLOAD |-> cnt < hdr_q.payload_len);

endmodule

`default_nettype wire

//--- ip_hdr_checksum.sv
`timescale 1ns/1ps
`default_nettype none

module ip_hdr_checksum import udp_pkg::*; (
    input  logic [15:0] total_length,
    input  logic [31:0] source_ip,
    input  logic [31:0] dest_ip,
    output logic [15:0] checksum
);

    logic [19:0] sum;
    logic [16:0] fold1;
    logic [15:0] fold2;

    // Identification, flags and the checksum word are all zero
    // and add nothing to the sum
    assign sum = 20'({IP_VER_IHL, 8'h00})
               + 20'(total_length)
               + 20'({IP_TTL, IP_PROTO_UDP})
               + 20'(source_ip[31:16])
               + 20'(source_ip[15:0])
               + 20'(dest_ip[31:16])
               + 20'(dest_ip[15:0]);

    // Two folds are enough for seven words
    assign fold1 = 17'(sum[15:0]) + 17'(sum[19:16]);
    assign fold2 = fold1[15:0] + 16'(fold1[16]);

    assign checksum = ~fold2;

endmodule

`default_nettype wire

//--- udp_pkg.sv
`default_nettype none

package udp_pkg;

    // Header sizes in bytes
    localparam int ETH_HDR_BYTES   = 14;
    localparam int IP_HDR_BYTES    = 20;
    localparam int UDP_HDR_BYTES   = 8;
    localparam int FRAME_HDR_BYTES = ETH_HDR_BYTES + IP_HDR_BYTES + UDP_HDR_BYTES;

    // Fixed protocol field values
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL     = 8'h45;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
    localparam logic [7:0]  IP_TTL         = 8'd64;
    localparam logic [15:0] UDP_SRC_PORT   = 16'd1234;
    localparam logic [47:0] MAC_BROADCAST  = 48'hffff_ffff_ffff;

    // One byte of a frame or payload stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } byte_beat_t;

    // Header record of an accepted datagram
    typedef struct packed {
        logic [31:0] src_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        // UDP length minus the UDP header
        logic [15:0] payload_len;
    } udp_rx_hdr_t;

    // Transmit request from the application
    typedef struct packed {
        logic [31:0] dst_ip;
        logic [15:0] dst_port;
        logic [15:0] payload_len;
    } udp_tx_hdr_t;

    typedef enum logic [1:0] {
        RX_HDR,
        RX_HDR_OUT,
        RX_PAYLOAD,
        RX_DRAIN
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HDR,
        TX_PAYLOAD
    } tx_state_e;

endpackage

`default_nettype wire
